//--- add_round_key.sv
// ==========================================================
// AddRoundKey: XORs the 128-bit state with the round key.
// ==========================================================
module add_round_key (
    input  aes_pkg::aes_state_t state_in,                     // State from the register bank.
    input  aes_pkg::aes_state_t round_key,                    // Key from the register bank.
    output aes_pkg::aes_state_t ark_state                     // Keyed state to the serializer.
);

    import aes_pkg::*;

    aes_state_t keyed;                                        // Byte-wise XOR result.

    // Each byte takes the key byte at the same index.
    always_comb
    begin
        for (int i = 0; i < STATE_BYTES; i++)
        begin
            keyed[i] = state_in[i] ^ round_key[i];
        end
    end

    assign ark_state = keyed;                                 // No register, zero latency.

endmodule

//--- aes_pkg.sv
// ==========================================================
// AES definitions: state and byte types, sizes, S-box
// constants and the register map of the host interface.
// ==========================================================
package aes_pkg;

    localparam int STATE_BYTES = 16;                          // Bytes in one AES state.
    localparam int WORD_BYTES  = 4;                           // State bytes per bus word.

    typedef logic [7:0] aes_byte_t;                           // One state byte.

    // Byte i sits at bits 8*i+7 : 8*i, so byte 0 is the least significant.
    typedef aes_byte_t [STATE_BYTES-1:0] aes_state_t;

    typedef logic [3:0] byte_idx_t;                           // Index of a byte in the state.

    localparam byte_idx_t LAST_BYTE = byte_idx_t'(STATE_BYTES - 1);  // Wrap point.

    // Field and affine constants of the S-box.
    localparam aes_byte_t GF_POLY       = 8'h1b;              // x^8+x^4+x^3+x+1 reduction.
    localparam aes_byte_t SBOX_AFFINE_C = 8'h63;              // Affine map constant.

    typedef logic [3:0] reg_word_t;                           // Word address on the bus.

    // Register map in word addresses.
    localparam reg_word_t REG_STATE0  = 4'd0;                 // State words 0 to 3.
    localparam reg_word_t REG_KEY0    = 4'd4;                 // Key words 4 to 7.
    localparam reg_word_t REG_CTRL    = 4'd8;                 // Bit 0 starts a run.
    localparam reg_word_t REG_STATUS  = 4'd9;                 // Bit 0 busy, bit 1 done.
    localparam reg_word_t REG_RESULT0 = 4'd12;                // Result words 12 to 15.

    localparam int CTRL_START_BIT  = 0;                       // Start bit in REG_CTRL.
    localparam int STATUS_BUSY_BIT = 0;                       // Busy flag in REG_STATUS.
    localparam int STATUS_DONE_BIT = 1;                       // Done flag in REG_STATUS.

endpackage

//--- aes_sub_core.sv
// ==========================================================
// AES round fragment: AddRoundKey then byte-serial SubBytes
// behind a Wishbone classic slave.
// ==========================================================
module aes_sub_core (
    input  logic            clk,
    input  logic            resetn,
    input  wb_pkg::wb_req_t wb_req,                           // Host bus request.
    output wb_pkg::wb_rsp_t wb_rsp                            // Host bus response.
);

    import aes_pkg::*;

    aes_state_t state_in;                                     // Plain state words.
    aes_state_t round_key;                                    // Key words.
    aes_state_t ark_state;                                    // State XOR key.
    aes_state_t result;                                       // Substituted state.
    aes_byte_t  ser_byte;                                     // Byte into the S-box.
    aes_byte_t  sub_byte;                                     // Byte out of the S-box.
    logic       load;
    logic       req;
    logic       sub_valid;
    logic       full;

    wb_regs i_wb_regs (
        .clk       (clk),
        .resetn    (resetn),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .state_in  (state_in),
        .round_key (round_key),
        .load      (load),
        .req       (req),
        .result    (result),
        .full      (full)
    );

    add_round_key i_add_round_key (
        .state_in  (state_in),
        .round_key (round_key),
        .ark_state (ark_state)
    );

    state_serializer i_state_serializer (
        .clk       (clk),
        .resetn    (resetn),
        .load      (load),
        .ark_state (ark_state),
        .req       (req),
        .ser_byte  (ser_byte)
    );

    // req doubles as the S-box input valid.
    sbox_unit i_sbox_unit (
        .clk       (clk),
        .resetn    (resetn),
        .in_byte   (ser_byte),
        .in_valid  (req),
        .sub_byte  (sub_byte),
        .sub_valid (sub_valid)
    );

    state_collector i_state_collector (
        .clk       (clk),
        .resetn    (resetn),
        .sub_byte  (sub_byte),
        .sub_valid (sub_valid),
        .result    (result),
        .full      (full)
    );

endmodule

//--- aes_sub_core_sva.sv
// ==========================================================
// Assertions on the Wishbone handshake and run status flags.
// ==========================================================
module aes_sub_core_sva (
    input logic            clk,
    input logic            resetn,
    input wb_pkg::wb_req_t wb_req,                            // Master side of the bus.
    input wb_pkg::wb_rsp_t wb_rsp,                            // Slave side of the bus.
    input logic            req,                               // Byte request to the datapath.
    input logic            busy,                              // Run in progress.
    input logic            full                               // Collector has 16 bytes.
);

    int fails;                                                // Failed assertions so far.

    initial fails = 0;

    // Ack only answers a live transfer.
    property ack_with_request;
        @(posedge clk) disable iff (!resetn)
            wb_rsp.ack |-> (wb_req.cyc && wb_req.stb);
    endproperty

    // Master keeps the transfer steady until ack.
    property request_held;
        @(posedge clk) disable iff (!resetn)
            (wb_req.cyc && wb_req.stb && !wb_rsp.ack)
                |=> (wb_req.cyc && wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we));
    endproperty

    property req_inside_run;
        @(posedge clk) disable iff (!resetn)
            req |-> busy;
    endproperty

    // Full only ends a run in progress.
    property full_inside_run;
        @(posedge clk) disable iff (!resetn)
            full |-> busy;
    endproperty

    a_ack_with_request: assert property (ack_with_request)
    else
    begin
        $error("ack seen without cyc and stb");
        fails++;
    end
    a_request_held:     assert property (request_held)
    else
    begin
        $error("transfer dropped or changed before ack");
        fails++;
    end
    a_req_inside_run:   assert property (req_inside_run)
    else
    begin
        $error("req high while not busy");
        fails++;
    end
    a_full_inside_run:  assert property (full_inside_run)
    else
    begin
        $error("full seen while not busy");
        fails++;
    end

endmodule

//--- sbox_unit.sv
// ==========================================================
// Byte S-box: GF(2^8) inverse followed by the AES affine map,
// with a registered result and valid flag.
// ==========================================================
module sbox_unit (
    input  logic               clk,
    input  logic               resetn,
    input  aes_pkg::aes_byte_t in_byte,                       // Byte from the serializer.
    input  logic               in_valid,                      // Byte is wanted this cycle.
    output aes_pkg::aes_byte_t sub_byte,                      // Substituted byte.
    output logic               sub_valid                      // sub_byte holds a new value.
);

    import aes_pkg::*;

    aes_byte_t inv_byte;                                      // Field inverse of in_byte.
    aes_byte_t aff_byte;                                      // After the affine map.

    // Multiply by x modulo the AES polynomial.
    function automatic aes_byte_t xtime(input aes_byte_t a);
        xtime = {a[6:0], 1'b0} ^ (a[7] ? GF_POLY : 8'h00);
    endfunction

    // Shift-and-add field multiply.
    function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            sh = xtime(sh);                                   // Next power of x times a.
        end
        gf_mul = acc;
    endfunction

    // a^254 = a^2 * a^4 * ... * a^128, which also maps 0 to 0.
    function automatic aes_byte_t gf_inv(input aes_byte_t a);
        aes_byte_t sq;
        aes_byte_t prod;
        sq   = gf_mul(a, a);
        prod = sq;
        for (int k = 2; k < 8; k++)
        begin
            sq   = gf_mul(sq, sq);                            // a^(2^k).
            prod = gf_mul(prod, sq);
        end
        gf_inv = prod;
    endfunction

    // b = a ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 0x63.
    function automatic aes_byte_t affine(input aes_byte_t a);
        affine = a ^ {a[6:0], a[7]} ^ {a[5:0], a[7:6]}
                   ^ {a[4:0], a[7:5]} ^ {a[3:0], a[7:4]} ^ SBOX_AFFINE_C;
    endfunction

    assign inv_byte = gf_inv(in_byte);
    assign aff_byte = affine(inv_byte);

    // One cycle latency, result held between requests.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            sub_byte  <= '0;
            sub_valid <= 1'b0;
        end
        else
        begin
            sub_valid <= in_valid;
            if (in_valid)
                sub_byte <= aff_byte;
        end
    end

endmodule

//--- src.f
aes_pkg.sv
wb_pkg.sv
add_round_key.sv
state_serializer.sv
sbox_unit.sv
state_collector.sv
wb_regs.sv
aes_sub_core.sv
aes_sub_core_sva.sv
tb_aes_sub_core.sv

//--- state_collector.sv
// ==========================================================
// State collector: writes 16 substituted bytes back into a
// state and pulses full after the last one.
// ==========================================================
module state_collector (
    input  logic                clk,
    input  logic                resetn,
    input  aes_pkg::aes_byte_t  sub_byte,                     // Byte from the S-box.
    input  logic                sub_valid,                    // sub_byte is new.
    output aes_pkg::aes_state_t result,                       // Gathered state.
    output logic                full                          // All 16 bytes written.
);

    import aes_pkg::*;

    byte_idx_t wr_idx;                                        // Slot for the next byte.

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            result <= '0;
            wr_idx <= '0;
            full   <= 1'b0;
        end
        else
        begin
            full <= sub_valid && (wr_idx == LAST_BYTE);       // Pulse after the wrap.
            if (sub_valid)
            begin
                result[wr_idx] <= sub_byte;
                if (wr_idx == LAST_BYTE)
                    wr_idx <= '0;
                else
                    wr_idx <= wr_idx + 1'b1;
            end
        end
    end

endmodule

//--- state_serializer.sv
// ==========================================================
// State serializer: holds 16 keyed bytes and hands one byte
// to the S-box per request, wrapping after the last one.
// ==========================================================
module state_serializer (
    input  logic                clk,
    input  logic                resetn,
    input  logic                load,                         // Capture ark_state.
    input  aes_pkg::aes_state_t ark_state,                    // Keyed state from AddRoundKey.
    input  logic                req,                          // S-box takes the current byte.
    output aes_pkg::aes_byte_t  ser_byte                      // Byte at the read index.
);

    import aes_pkg::*;

    aes_state_t bytes_q;                                      // Stored state.
    byte_idx_t  rd_idx;                                       // Next byte to hand out.

    // Capture the whole state in one edge.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            bytes_q <= '0;
        end
        else if (load)
        begin
            bytes_q <= ark_state;
        end
    end

    // Read index walks 0..15 once per req.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            rd_idx <= '0;
        end
        else if (req)
        begin
            if (rd_idx == LAST_BYTE)
                rd_idx <= '0;                                 // All 16 bytes read.
            else
                rd_idx <= rd_idx + 1'b1;
        end
    end

    assign ser_byte = bytes_q[rd_idx];                        // Combinational from the index.

endmodule

//--- tb_aes_sub_core.sv
// ==========================================================
// Testbench for the AES SubBytes core: random runs over the
// Wishbone port, checked against a reference S-box model.
// ==========================================================
module tb_aes_sub_core;

    import aes_pkg::*;
    import wb_pkg::*;

    localparam int CLK_PERIOD     = 40;                       // Time units per cycle.
    localparam int RESET_CYCLES   = 8;
    localparam int RUNS           = 40;                       // Random state/key pairs.
    localparam int CYCLES_PER_RUN = 200;                      // Generous bound for one run.
    localparam int POLL_LIMIT     = 100;                      // Status reads before giving up.
    localparam int WATCHDOG_TIME  = RUNS * CYCLES_PER_RUN * CLK_PERIOD;

    logic      clk;
    logic      resetn;
    wb_req_t   wb_req;                                        // Driven on the falling edge.
    wb_rsp_t   wb_rsp;
    aes_byte_t sbox_tab [256];                                // Model S-box table.

    aes_sub_core i_aes_sub_core (
        .clk    (clk),
        .resetn (resetn),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    bind wb_regs aes_sub_core_sva i_aes_sub_core_sva (
        .clk    (clk),
        .resetn (resetn),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .req    (req),
        .busy   (busy),
        .full   (full)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Polynomial product, then reduction by x^8+x^4+x^3+x+1.
    function automatic aes_byte_t model_mul(input aes_byte_t a, input aes_byte_t b);
        logic [14:0] p;
        p = '0;
        for (int i = 0; i < 8; i++)
            if (b[i])
                p = p ^ (15'(a) << i);
        for (int k = 14; k >= 8; k--)
            if (p[k])
                p = p ^ (15'h11b << (k - 8));
        return p[7:0];
    endfunction

    // Brute-force inverse, then the FIPS-197 affine bit equation.
    function automatic aes_byte_t model_sbox(input aes_byte_t a);
        aes_byte_t inv;
        aes_byte_t c;
        aes_byte_t out;
        inv = 8'h00;                                          // Zero maps to zero.
        c   = 8'h63;
        for (int b = 1; b < 256; b++)
            if (a != 8'h00 && model_mul(a, aes_byte_t'(b)) == 8'h01)
                inv = aes_byte_t'(b);
        for (int i = 0; i < 8; i++)
            out[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
                   ^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8] ^ c[i];
        return out;
    endfunction

    function automatic aes_state_t expected_state(input aes_state_t s, input aes_state_t k);
        aes_state_t e;
        for (int i = 0; i < STATE_BYTES; i++)
            e[i] = sbox_tab[s[i] ^ k[i]];                     // SubBytes of state XOR key.
        return e;
    endfunction

    function automatic aes_state_t random_state();
        aes_state_t s;
        for (int i = 0; i < STATE_BYTES; i++)
            s[i] = aes_byte_t'($urandom());
        return s;
    endfunction

    // Byte i sits in word i/4 at bit 8*(i mod 4).
    function automatic wb_data_t pack_word(input aes_state_t s, input int w);
        wb_data_t d;
        for (int b = 0; b < 4; b++)
            d[8*b +: 8] = s[4*w + b];
        return d;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
        if (act !== exp)
        begin
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_state(input string name, input aes_state_t exp, input aes_state_t act);
        if (act !== exp)
        begin
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // Called at a falling edge; holds the request through the ack edge.
    task automatic wb_write(input reg_word_t word, input wb_data_t data);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b1;
        wb_req.adr   = {word, 2'b00};                         // Byte address.
        wb_req.dat_w = data;
        wb_req.sel   = '1;
        do @(negedge clk); while (!wb_rsp.ack);
        @(negedge clk);
        wb_req = '0;
    endtask

    task automatic wb_read(input reg_word_t word, output wb_data_t data);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b0;
        wb_req.adr   = {word, 2'b00};
        wb_req.dat_w = '0;
        wb_req.sel   = '1;
        do @(negedge clk); while (!wb_rsp.ack);
        data = wb_rsp.dat_r;                                  // Valid while ack is high.
        @(negedge clk);
        wb_req = '0;
    endtask

    task automatic write_words(input reg_word_t base, input aes_state_t s);
        for (int w = 0; w < 4; w++)
            wb_write(reg_word_t'(base + w), pack_word(s, w));
    endtask

    task automatic read_result(output aes_state_t act);
        wb_data_t d;
        for (int w = 0; w < 4; w++)
        begin
            wb_read(reg_word_t'(REG_RESULT0 + w), d);
            for (int b = 0; b < 4; b++)
                act[4*w + b] = d[8*b +: 8];
        end
    endtask

    task automatic wait_done();
        wb_data_t d;
        int       polls;
        polls = 0;
        d     = '0;
        while (!d[1])
        begin
            if (polls == POLL_LIMIT)
                fail_run("Status never reported done within the poll limit");
            wb_read(REG_STATUS, d);
            polls++;
        end
    endtask

    task automatic run_core(input aes_state_t s, input aes_state_t k, output aes_state_t act);
        write_words(REG_STATE0, s);
        write_words(REG_KEY0, k);
        wb_write(REG_CTRL, 32'h1);                            // Start bit.
        wait_done();
        read_result(act);
    endtask

    initial
    begin
        #(WATCHDOG_TIME);
        fail_run("Simulation hung: watchdog time ran out");
    end

    // Bound assertion failures end the run.
    always @(negedge clk)
    begin
        if (i_aes_sub_core.i_wb_regs.i_aes_sub_core_sva.fails != 0)
            fail_run("A bound assertion on the bus or run status failed");
    end

    initial
    begin
        aes_state_t  s;
        aes_state_t  k;
        aes_state_t  s2;
        aes_state_t  act;
        wb_data_t    d;
        int unsigned seed_val;
        wb_req   = '0;
        resetn   = 1'b0;
        seed_val = $urandom(32'hf174);                        // Fixed seed, set once.
        for (int a = 0; a < 256; a++)
            sbox_tab[a] = model_sbox(aes_byte_t'(a));
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        // Reset values.
        wb_read(REG_STATUS, d);
        check_word("status", 32'h0, d);
        for (int w = 0; w < 4; w++)
        begin
            wb_read(reg_word_t'(REG_RESULT0 + w), d);
            check_word("result_word", 32'h0, d);
        end

        // Register readback and unmapped words.
        s = random_state();
        k = random_state();
        write_words(REG_STATE0, s);
        write_words(REG_KEY0, k);
        for (int w = 0; w < 4; w++)
        begin
            wb_read(reg_word_t'(REG_STATE0 + w), d);
            check_word("state_word", pack_word(s, w), d);
            wb_read(reg_word_t'(REG_KEY0 + w), d);
            check_word("key_word", pack_word(k, w), d);
        end
        wb_read(4'd8, d);
        check_word("ctrl_word", 32'h0, d);
        wb_read(4'd10, d);
        check_word("unmapped_10", 32'h0, d);
        wb_read(4'd11, d);
        check_word("unmapped_11", 32'h0, d);

        // Edge bytes.
        run_core('0, '0, act);
        check_state("result_zero", {16{8'h63}}, act);
        s = random_state();
        run_core(s, s, act);
        check_state("result_equal", {16{8'h63}}, act);
        run_core({16{8'h01}}, '0, act);
        check_state("result_one", {16{8'h7c}}, act);

        // Random pairs against the model.
        for (int r = 0; r < RUNS; r++)
        begin
            s = random_state();
            k = random_state();
            run_core(s, k, act);
            check_state("result", expected_state(s, k), act);
        end

        // Start and state writes while busy are dropped.
        s  = random_state();
        k  = random_state();
        s2 = random_state();
        write_words(REG_STATE0, s);
        write_words(REG_KEY0, k);
        wb_write(REG_CTRL, 32'h1);
        wb_read(REG_STATUS, d);
        check_word("status_busy", 32'h1, d);
        wb_write(REG_CTRL, 32'h1);                            // Second start, ignored.
        write_words(REG_STATE0, s2);                          // Ignored while busy.
        wait_done();
        read_result(act);
        check_state("result_busy", expected_state(s, k), act);
        for (int w = 0; w < 4; w++)
        begin
            wb_read(reg_word_t'(REG_STATE0 + w), d);
            check_word("state_word_kept", pack_word(s, w), d);
        end

        // New start clears done and replaces the result.
        k = random_state();
        write_words(REG_STATE0, s2);
        write_words(REG_KEY0, k);
        wb_write(REG_CTRL, 32'h1);
        wb_read(REG_STATUS, d);
        check_word("status_restart", 32'h1, d);
        wait_done();
        wb_read(REG_STATUS, d);
        check_word("status_done", 32'h2, d);
        read_result(act);
        check_state("result_new", expected_state(s2, k), act);

        if (i_aes_sub_core.i_wb_regs.i_aes_sub_core_sva.fails == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            $display("Checks failed");
            $fatal(1, "assertion failures found");
        end
    end

endmodule

//--- wb_pkg.sv
// ==========================================================
// Wishbone classic bus widths and the request and response
// bundles exchanged between master and slave.
// ==========================================================
package wb_pkg;

    localparam int WB_ADR_W = 6;                              // Byte address, word in [5:2].
    localparam int WB_DAT_W = 32;                             // Data bus width.
    localparam int WB_SEL_W = WB_DAT_W / 8;                   // One select per byte lane.

    typedef logic [WB_DAT_W-1:0] wb_data_t;                   // One bus data word.

    // Driven by the master.
    typedef struct packed {
        logic                cyc;                             // Bus cycle in progress.
        logic                stb;                             // Valid transfer.
        logic                we;                              // Write when high.
        logic [WB_ADR_W-1:0] adr;                             // Byte address.
        wb_data_t            dat_w;                           // Write data.
        logic [WB_SEL_W-1:0] sel;                             // Byte lane selects.
    } wb_req_t;

    // Driven by the slave.
    typedef struct packed {
        logic     ack;                                        // Transfer done.
        wb_data_t dat_r;                                      // Read data, valid with ack.
    } wb_rsp_t;

endpackage

//--- wb_regs.sv
// ==========================================================
// Wishbone classic register bank with start, busy and done
// status, and the load and request sequencer of the datapath.
// ==========================================================
module wb_regs (
    input  logic                clk,
    input  logic                resetn,
    input  wb_pkg::wb_req_t     wb_req,                       // From the bus master.
    output wb_pkg::wb_rsp_t     wb_rsp,                       // To the bus master.
    output aes_pkg::aes_state_t state_in,                     // State words to AddRoundKey.
    output aes_pkg::aes_state_t round_key,                    // Key words to AddRoundKey.
    output logic                load,                         // Serializer capture pulse.
    output logic                req,                          // One byte per cycle.
    input  aes_pkg::aes_state_t result,                       // Substituted state.
    input  logic                full                          // Collector has 16 bytes.
);

    import aes_pkg::*;
    import wb_pkg::*;

    reg_word_t word;                                          // Word address of the access.
    logic [1:0] lane;                                         // Word within a 4-word group.
    logic      access;                                        // New transfer this cycle.
    logic      wr;                                            // New write this cycle.
    logic      start;                                         // Accepted start request.
    logic      ack;
    wb_data_t  dat_r;
    wb_data_t  rd_data;                                       // Read mux output.
    logic      busy;
    logic      done;
    byte_idx_t req_cnt;                                       // Requests issued so far.

    // sel is ignored, only full-word access is supported.
    assign word   = wb_req.adr[WB_ADR_W-1:2];
    assign lane   = word[1:0];
    assign access = wb_req.cyc && wb_req.stb && !ack;         // Ack low, so a fresh transfer.
    assign wr     = access && wb_req.we;
    assign start  = wr && (word == REG_CTRL) && wb_req.dat_w[CTRL_START_BIT] && !busy;

    // Read mux; the control word and holes read as zero.
    always_comb
    begin
        rd_data = '0;
        case (word[3:2])
            REG_STATE0[3:2]:  rd_data = state_in[WORD_BYTES*lane +: WORD_BYTES];
            REG_KEY0[3:2]:    rd_data = round_key[WORD_BYTES*lane +: WORD_BYTES];
            REG_RESULT0[3:2]: rd_data = result[WORD_BYTES*lane +: WORD_BYTES];
            default:
            begin
                if (word == REG_STATUS)
                begin
                    rd_data[STATUS_BUSY_BIT] = busy;
                    rd_data[STATUS_DONE_BIT] = done;
                end
            end
        endcase
    end

    // Single-cycle ack, read data captured with it.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ack   <= 1'b0;
            dat_r <= '0;
        end
        else
        begin
            ack <= access;
            if (access)
                dat_r <= rd_data;
        end
    end

    // State and key words, frozen while a run is busy.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_in  <= '0;
            round_key <= '0;
        end
        else if (wr && !busy)
        begin
            if (word[3:2] == REG_STATE0[3:2])
                state_in[WORD_BYTES*lane +: WORD_BYTES] <= wb_req.dat_w;
            else if (word[3:2] == REG_KEY0[3:2])
                round_key[WORD_BYTES*lane +: WORD_BYTES] <= wb_req.dat_w;
        end
    end

    // Sequencer: start -> load -> 16 req cycles -> wait for full.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            load    <= 1'b0;
            req     <= 1'b0;
            req_cnt <= '0;
        end
        else
        begin
            load <= start;                                    // Pulse in the cycle after ack edge.
            if (start)
            begin
                busy <= 1'b1;
                done <= 1'b0;                                 // New run clears done.
            end
            else if (full)
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (load)
            begin
                req     <= 1'b1;
                req_cnt <= '0;
            end
            else if (req)
            begin
                if (req_cnt == LAST_BYTE)
                    req <= 1'b0;                              // 16th byte requested.
                req_cnt <= req_cnt + 1'b1;
            end
        end
    end

    assign wb_rsp.ack   = ack;
    assign wb_rsp.dat_r = dat_r;

endmodule
